// File: hw/stepper_pkg.sv
// Phase angle, microstep, quadrant and step count types with their widths
package stepper_pkg;

  // ------------------------------
  // Phase angle
  // ------------------------------

  localparam int PHASE_BITS = 8;             // 256 positions per electrical turn

  typedef logic [PHASE_BITS-1:0] phase_t;    // Wraps modulo 256

  // Quadrant is the top two angle bits
  typedef logic [1:0] quadrant_t;

  // ------------------------------
  // Step input and step count
  // ------------------------------

  localparam int MICROSTEP_BITS = 8;

  typedef logic [MICROSTEP_BITS-1:0] microstep_t;   // Angle increment per step

  localparam int STEP_COUNT_BITS = 32;

  // Two's complement, wraps at the ends
  typedef logic signed [STEP_COUNT_BITS-1:0] step_count_t;

endpackage

// File: hw/bridge_pkg.sv
// Current, sine magnitude, duty and PWM counter widths, quadrant polarity codes
package bridge_pkg;

  // ------------------------------
  // Duty widths
  // ------------------------------

  localparam int CURRENT_BITS = 4;                     // Top bits of the 8-bit setting
  localparam int TABLE_BITS   = 8;                     // Sine magnitude
  localparam int DUTY_BITS    = CURRENT_BITS + TABLE_BITS;

  typedef logic [DUTY_BITS-1:0] duty_t;
  typedef logic [DUTY_BITS-1:0] pwm_cnt_t;             // One PWM period is 4096 cycles

  // ------------------------------
  // Coil polarity per quadrant
  // ------------------------------

  // Bit order b2, b1, a2, a1 from the MSB down
  localparam logic [3:0] POLARITY_Q0 = 4'b1010;
  localparam logic [3:0] POLARITY_Q1 = 4'b0110;
  localparam logic [3:0] POLARITY_Q2 = 4'b0101;
  localparam logic [3:0] POLARITY_Q3 = 4'b1001;

endpackage

// File: hw/drive_ifs.sv
// phase_if and duty_if interfaces with their modports
interface phase_if;
  stepper_pkg::phase_t      phase;        // Electrical angle
  stepper_pkg::step_count_t step_count;   // Signed position
  logic                     moved;        // High one cycle after an accepted step
  logic                     dir_r;        // Direction of the last step

  modport seq (
    output phase, step_count, moved, dir_r
  );

  modport mod (
    input phase, step_count, moved, dir_r
  );
endinterface

interface duty_if;
  logic                   vref_a;         // PWM enable, coil A
  logic                   vref_b;         // PWM enable, coil B
  stepper_pkg::quadrant_t quadrant;       // Latched at each wrap
  logic                   period_start;   // First cycle of a PWM period

  modport mod (
    output vref_a, vref_b, quadrant, period_start
  );

  modport out (
    input vref_a, vref_b, quadrant, period_start
  );
endinterface

// File: hw/step_sequencer.sv
// Step edge detection, phase angle accumulator and signed step count
module step_sequencer (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    step,
  input  logic                    dir,
  input  stepper_pkg::microstep_t microsteps,
  phase_if.seq                    ph
);

  logic                     step_q;     // Step level at the previous edge
  logic                     step_rise;
  stepper_pkg::step_count_t delta;      // Signed increment for this step

  // ------------------------------
  // Edge detect
  // ------------------------------

  // Step history for the rising edge
  always_ff @(posedge clk) begin
    step_q <= step;
  end

  assign step_rise = step & ~step_q;

  // Zero-extend first, then apply direction
  assign delta = dir ? stepper_pkg::step_count_t'(microsteps)
                     : -stepper_pkg::step_count_t'(microsteps);

  // ------------------------------
  // Angle and count
  // ------------------------------

  always_ff @(posedge clk) begin
    if (resetn) begin
      ph.phase      <= '0;
      ph.step_count <= '0;
      ph.moved      <= 1'b0;
      ph.dir_r      <= 1'b0;
    end else begin
      ph.moved <= step_rise;                     // One-cycle pulse
      if (step_rise) begin
        // Low byte of delta, wraps modulo 256
        ph.phase      <= ph.phase + stepper_pkg::phase_t'(delta);
        ph.step_count <= ph.step_count + delta;  // Plain two's complement wrap
        ph.dir_r      <= dir;
      end
    end
  end

endmodule

// File: hw/coil_modulator.sv
// Quarter-wave sine table, current scaling, PWM counter and vref compare
module coil_modulator (
  input  logic       clk,
  input  logic       resetn,
  input  logic [7:0] current,
  phase_if.mod       ph,
  duty_if.mod        dq
);

  localparam int TB = bridge_pkg::TABLE_BITS;

  // round(255 * sin(2*pi*k/256)), k = 0..63
  localparam logic [TB-1:0] SINE_TAB [64] = '{
    8'd0,   8'd6,   8'd13,  8'd19,  8'd25,  8'd31,  8'd37,  8'd44,
    8'd50,  8'd56,  8'd62,  8'd68,  8'd74,  8'd80,  8'd86,  8'd92,
    8'd98,  8'd103, 8'd109, 8'd115, 8'd120, 8'd126, 8'd131, 8'd136,
    8'd142, 8'd147, 8'd152, 8'd157, 8'd162, 8'd167, 8'd171, 8'd176,
    8'd180, 8'd185, 8'd189, 8'd193, 8'd197, 8'd201, 8'd205, 8'd208,
    8'd212, 8'd215, 8'd219, 8'd222, 8'd225, 8'd228, 8'd231, 8'd233,
    8'd236, 8'd238, 8'd240, 8'd242, 8'd244, 8'd246, 8'd247, 8'd249,
    8'd250, 8'd251, 8'd252, 8'd253, 8'd254, 8'd254, 8'd255, 8'd255
  };

  // |sin| of an angle, folded into the quarter table
  function automatic logic [TB-1:0] sine_mag(input stepper_pkg::phase_t p);
    logic [5:0] off;
    off = p[5:0];
    if (!p[6])
      sine_mag = SINE_TAB[off];          // Rising part of the quarter
    else if (off == 6'd0)
      sine_mag = 8'd255;                 // Peak, entry 64
    else
      sine_mag = SINE_TAB[6'd0 - off];   // Mirrored, 64 - off
  endfunction

  logic [TB-1:0]                       mag_a, mag_b;
  logic [bridge_pkg::CURRENT_BITS-1:0] cur_scale;
  bridge_pkg::duty_t                   duty_a_new, duty_b_new;
  bridge_pkg::duty_t                   duty_a_q, duty_b_q;  // Held for the period
  bridge_pkg::duty_t                   duty_a_eff, duty_b_eff;
  bridge_pkg::pwm_cnt_t                cnt;
  logic                                wrap;

  // ------------------------------
  // Magnitudes and duty
  // ------------------------------

  assign mag_a = sine_mag(ph.phase + 8'd64);   // |cos|
  assign mag_b = sine_mag(ph.phase);           // |sin|

  assign cur_scale  = current[7 -: bridge_pkg::CURRENT_BITS];
  assign duty_a_new = bridge_pkg::duty_t'(mag_a) * bridge_pkg::duty_t'(cur_scale);
  assign duty_b_new = bridge_pkg::duty_t'(mag_b) * bridge_pkg::duty_t'(cur_scale);

  // ------------------------------
  // PWM counter and compare
  // ------------------------------

  assign wrap = (cnt == '0);

  // New duty applies from the latch edge on
  assign duty_a_eff = wrap ? duty_a_new : duty_a_q;
  assign duty_b_eff = wrap ? duty_b_new : duty_b_q;

  always_ff @(posedge clk) begin
    if (wrap) begin
      duty_a_q <= duty_a_new;
      duty_b_q <= duty_b_new;
    end
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      cnt             <= '0;
      dq.vref_a       <= 1'b0;
      dq.vref_b       <= 1'b0;
      dq.quadrant     <= '0;
      dq.period_start <= 1'b0;
    end else begin
      cnt             <= cnt + 1'b1;           // Free running, 4096 cycles
      dq.period_start <= wrap;
      dq.vref_a       <= (cnt < duty_a_eff);   // duty_a cycles high per period
      dq.vref_b       <= (cnt < duty_b_eff);
      if (wrap)
        dq.quadrant <= ph.phase[7:6];
    end
  end

endmodule

// File: hw/bridge_output.sv
// Coil polarity from quadrant, decay and brake selection for both bridges
module bridge_output #(
  parameter bit vref_off_brake = 1'b1   // Brake decay while PWM is off
) (
  duty_if.out  dq,
  input  logic enable,
  input  logic brake,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  logic [3:0] polarity;   // b2 b1 a2 a1
  logic       brake_a, brake_b;
  logic       drive_a, drive_b;

  // ------------------------------
  // Polarity
  // ------------------------------

  always_comb begin
    case (dq.quadrant)
      2'd0:    polarity = bridge_pkg::POLARITY_Q0;
      2'd1:    polarity = bridge_pkg::POLARITY_Q1;
      2'd2:    polarity = bridge_pkg::POLARITY_Q2;
      default: polarity = bridge_pkg::POLARITY_Q3;
    endcase
  end

  // ------------------------------
  // Decay
  // ------------------------------

  if (vref_off_brake) begin : g_vref_brake
    assign brake_a = (~enable & brake) | ~dq.vref_a;
    assign brake_b = (~enable & brake) | ~dq.vref_b;
  end else begin : g_plain_brake
    assign brake_a = brake;
    assign brake_b = brake;
  end

  assign drive_a = enable & dq.vref_a;
  assign drive_b = enable & dq.vref_b;

  // Both legs of an idle coil take its brake value
  assign phase_a1 = drive_a ? polarity[0] : brake_a;
  assign phase_a2 = drive_a ? polarity[1] : brake_a;
  assign phase_b1 = drive_b ? polarity[2] : brake_b;
  assign phase_b2 = drive_b ? polarity[3] : brake_b;

endmodule

// File: hw/dual_hbridge.sv
// Dual H-bridge stepper drive top level, sequencer to modulator to bridge stage
module dual_hbridge #(
  parameter bit vref_off_brake = 1'b1
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     step,
  input  logic                     dir,
  input  logic                     enable,
  input  logic                     brake,
  input  logic [7:0]               microsteps,
  input  logic [7:0]               current,
  output logic                     phase_a1,
  output logic                     phase_a2,
  output logic                     phase_b1,
  output logic                     phase_b2,
  output logic                     vref_a,
  output logic                     vref_b,
  output stepper_pkg::step_count_t step_count
);

  phase_if ph ();   // Angle and count
  duty_if  dq ();   // PWM enables and quadrant

  step_sequencer u_seq (
    .clk        (clk),
    .resetn     (resetn),
    .step       (step),
    .dir        (dir),
    .microsteps (microsteps),
    .ph         (ph)
  );

  coil_modulator u_mod (
    .clk     (clk),
    .resetn  (resetn),
    .current (current),
    .ph      (ph),
    .dq      (dq)
  );

  bridge_output #(
    .vref_off_brake (vref_off_brake)
  ) u_out (
    .dq       (dq),
    .enable   (enable),
    .brake    (brake),
    .phase_a1 (phase_a1),
    .phase_a2 (phase_a2),
    .phase_b1 (phase_b1),
    .phase_b2 (phase_b2)
  );

  assign step_count = ph.step_count;   // One cycle after the step edge
  assign vref_a     = dq.vref_a;
  assign vref_b     = dq.vref_b;

endmodule

// File: verif/dual_hbridge_chk.sv
// Bound assertions on coil leg pairs while braking and on vref through reset
module dual_hbridge_chk #(
  parameter bit vref_off_brake = 1'b1
) (
  input logic clk,
  input logic resetn,
  input logic enable,
  input logic brake,
  input logic vref_a,
  input logic vref_b,
  input logic phase_a1,
  input logic phase_a2,
  input logic phase_b1,
  input logic phase_b2
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;   // Failed assertions so far

  // Disabled and braking, both legs of a coil sit at the same level
  a_brake_a: assert property (@(posedge clk) disable iff (resetn)
    (vref_off_brake && !enable && brake) |-> (phase_a1 == phase_a2))
    else begin
      $error("Coil A legs driven apart while braking with the drive disabled");
      fail_count++;
    end

  a_brake_b: assert property (@(posedge clk) disable iff (resetn)
    (vref_off_brake && !enable && brake) |-> (phase_b1 == phase_b2))
    else begin
      $error("Coil B legs driven apart while braking with the drive disabled");
      fail_count++;
    end

  // First wrap is the edge after reset drops, vref low until then
  a_vref_reset: assert property (@(posedge clk) resetn |=> (!vref_a && !vref_b))
    else begin
      $error("vref high before the first PWM wrap after reset");
      fail_count++;
    end

endmodule

// Checker on the top-level ports around the bridge stage
bind dual_hbridge dual_hbridge_chk #(.vref_off_brake(vref_off_brake)) u_chk (
  .clk      (clk),
  .resetn   (resetn),
  .enable   (enable),
  .brake    (brake),
  .vref_a   (vref_a),
  .vref_b   (vref_b),
  .phase_a1 (phase_a1),
  .phase_a2 (phase_a2),
  .phase_b1 (phase_b1),
  .phase_b2 (phase_b2)
);

// File: verif/dual_hbridge_mon.sv
// Reference model of angle, count, duty and bridge outputs, compared every cycle
module dual_hbridge_mon #(
  parameter int PERIODS_PER_TEST = 2,
  parameter bit vref_off_brake   = 1'b1
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic               step,
  input  logic               dir,
  input  logic               enable,
  input  logic               brake,
  input  logic [7:0]         microsteps,
  input  logic [7:0]         current,
  input  logic               phase_a1,
  input  logic               phase_a2,
  input  logic               phase_b1,
  input  logic               phase_b2,
  input  logic               vref_a,
  input  logic               vref_b,
  input  logic signed [31:0] step_count,
  output int                 tests_done,
  output int                 tests_passed,
  output int                 tests_failed,
  output int                 error_count
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int  PERIOD = 4096;            // PWM cycles per period
  localparam real PI     = 3.14159265358979;

  logic [7:0]         angle, last_angle;    // Model angle, and its value at the last edge
  logic [7:0]         last_cur;             // Current sampled at the last edge
  logic signed [31:0] count;                // Model step count
  logic               step_prev;
  logic               rst_seen = 1'b0;
  logic               in_period;
  logic [1:0]         exp_quad;             // Quadrant latched at the wrap
  int                 k, pcnt, duty_a, duty_b, hi_a, hi_b, periods;
  int                 test_errs = 0;
  int                 done_n = 0, pass_n = 0, fail_n = 0, err_n = 0;

  assign tests_done   = done_n;
  assign tests_passed = pass_n;
  assign tests_failed = fail_n;
  assign error_count  = err_n;

  // round(255 * |sin|) or round(255 * |cos|) of an angle
  function automatic int sine_ref(input logic [7:0] a, input bit cosine);
    real x;
    x = 2.0 * PI * $itor(a) / 256.0;
    x = cosine ? $cos(x) : $sin(x);
    if (x < 0.0)
      x = -x;
    return $rtoi(255.0 * x + 0.5);
  endfunction

  // Expected {b2, b1, a2, a1}
  function automatic logic [3:0] phases_ref(input logic va, vb, en, br, input logic [1:0] q);
    logic [3:0] pol;
    logic       ba, bb;
    case (q)
      2'd0:    pol = 4'b1010;
      2'd1:    pol = 4'b0110;
      2'd2:    pol = 4'b0101;
      default: pol = 4'b1001;
    endcase
    ba = vref_off_brake ? ((!en && br) || !va) : br;   // Decay while off
    bb = vref_off_brake ? ((!en && br) || !vb) : br;
    return {(en && vb) ? pol[3:2] : {bb, bb}, (en && va) ? pol[1:0] : {ba, ba}};
  endfunction

  task automatic mismatch(input string what, input longint got, input longint exp);
    err_n++;
    test_errs++;
    $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
  endtask

  task automatic compare_outputs(input logic va, vb, input logic signed [31:0] cnt);
    logic [3:0] ph;
    ph = phases_ref(va, vb, enable, brake, exp_quad);
    if (step_count !== cnt)
      mismatch("step_count", step_count, cnt);
    if ({vref_b, vref_a} !== {vb, va})
      mismatch("vref {b,a}", {vref_b, vref_a}, {vb, va});
    if ({phase_b2, phase_b1, phase_a2, phase_a1} !== ph)
      mismatch("phases {b2,b1,a2,a1}", {phase_b2, phase_b1, phase_a2, phase_a1}, ph);
  endtask

  // High cycle totals, then a report line when a test's periods are done
  task automatic close_period();
    if (hi_a != duty_a)
      mismatch("vref_a high cycles", hi_a, duty_a);
    if (hi_b != duty_b)
      mismatch("vref_b high cycles", hi_b, duty_b);
    periods++;
    if (periods % PERIODS_PER_TEST == 0) begin
      $display("Test %0d finished, %0d mismatches", done_n, test_errs);
      if (test_errs == 0)
        pass_n++;
      else
        fail_n++;
      done_n++;
      test_errs = 0;
    end
  endtask

  // ------------------------------
  // Per-cycle model
  // ------------------------------

  always @(posedge clk) begin
    if (resetn) begin
      if (rst_seen)
        compare_outputs(1'b0, 1'b0, 32'sd0);   // Reset values
      rst_seen  = 1'b1;
      angle     = '0;
      count     = '0;
      in_period = 1'b0;
      exp_quad  = '0;
      k         = 0;
      periods   = 0;
    end else begin
      if (k % PERIOD == 1) begin              // First cycle after a wrap edge
        if (in_period)
          close_period();
        duty_a    = sine_ref(last_angle, 1'b1) * int'(last_cur[7:4]);
        duty_b    = sine_ref(last_angle, 1'b0) * int'(last_cur[7:4]);
        exp_quad  = last_angle[7:6];
        in_period = 1'b1;
        pcnt      = 0;
        hi_a      = 0;
        hi_b      = 0;
      end
      compare_outputs(in_period && pcnt < duty_a, in_period && pcnt < duty_b, count);
      hi_a += int'(vref_a);
      hi_b += int'(vref_b);
      pcnt++;
      last_angle = angle;
      last_cur   = current;
      if (step && !step_prev) begin           // Accepted step edge
        angle = dir ? angle + microsteps : angle - microsteps;
        count = dir ? count + $signed({24'd0, microsteps})
                    : count - $signed({24'd0, microsteps});
      end
      k++;
    end
    step_prev = step;
  end

endmodule

// File: verif/dual_hbridge_tb.sv
// Testbench top with clock, reset, seeded random stimulus, watchdog, DUT and summary
module dual_hbridge_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS        = 6;
  localparam int PERIODS_PER_TEST = 2;
  localparam int PERIOD_CYCLES    = 4096;
  localparam int RESET_CYCLES     = 8;
  localparam int CLK_NS           = 8;
  // Every test period plus one spare period
  localparam int WATCHDOG_NS =
    (RESET_CYCLES + (NUM_TESTS * PERIODS_PER_TEST + 1) * PERIOD_CYCLES) * CLK_NS;

  logic               clk, resetn, step, dir, enable, brake;
  logic [7:0]         microsteps, current;
  logic               phase_a1, phase_a2, phase_b1, phase_b2;
  logic               vref_a, vref_b;
  logic signed [31:0] step_count;
  int                 seed, stim_cycle, gap_left;
  int                 tests_done, tests_passed, tests_failed, error_count;

  dual_hbridge #(.vref_off_brake(1'b1)) dut (.*);

  dual_hbridge_mon #(.PERIODS_PER_TEST(PERIODS_PER_TEST), .vref_off_brake(1'b1)) u_mon (.*);

  // Current, enable and brake for one PWM period
  task automatic set_period_inputs(input int test_idx);
    current = 8'($random(seed));
    enable  = 1'($random(seed));
    brake   = 1'($random(seed));
    case (test_idx)
      0, 1:    enable  = 1'b1;              // Driven, all quadrants
      2:       current = current & 8'h0f;   // Top bits zero, no duty
      3:       enable  = 1'b0;
      4:       brake   = 1'b1;
      default: ;
    endcase
  endtask

  // One-cycle step pulse, then a random low gap of at least one cycle
  task automatic drive_step(input int test_idx);
    if (gap_left > 0) begin
      step = 1'b0;
      gap_left--;
    end else begin
      step       = 1'b1;
      dir        = 1'($random(seed));
      microsteps = 8'($random(seed));
      if (test_idx != 1)
        microsteps = microsteps & 8'h0f;    // Fine steps
      gap_left = (test_idx == 1) ? 1 + int'($unsigned($random(seed)) % 4)
                                 : 1 + int'($unsigned($random(seed)) % 300);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  initial begin
    int test_idx;
    seed       = 54367;
    resetn     = 1'b1;
    step       = 1'b0;
    dir        = 1'b0;
    enable     = 1'b0;
    brake      = 1'b0;
    microsteps = '0;
    current    = '0;
    gap_left   = 0;
    stim_cycle = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    resetn = 1'b0;                          // Next edge is the first wrap
    forever begin
      test_idx = stim_cycle / (PERIOD_CYCLES * PERIODS_PER_TEST);
      if (stim_cycle % PERIOD_CYCLES == 0)
        set_period_inputs(test_idx);        // One cycle ahead of the wrap
      drive_step(test_idx);
      stim_cycle++;
      @(posedge clk);
      #1;
    end
  end

  initial begin
    wait (tests_done == NUM_TESTS);
    @(posedge clk);
    $display("Tests passed %0d, failed %0d, mismatches %0d, assertion failures %0d",
             tests_passed, tests_failed, error_count, dut.u_chk.fail_count);
    if (tests_failed == 0 && error_count == 0 && dut.u_chk.fail_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule

// File: dual_hbridge.f
hw/stepper_pkg.sv
hw/bridge_pkg.sv
hw/drive_ifs.sv
hw/step_sequencer.sv
hw/coil_modulator.sv
hw/bridge_output.sv
hw/dual_hbridge.sv
verif/dual_hbridge_chk.sv
verif/dual_hbridge_mon.sv
verif/dual_hbridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the dual H-bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module dual_hbridge_tb -f dual_hbridge.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vdual_hbridge_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "No errors"; then
  exit 0
fi
exit 1
